//--- files.f
rtl/busPkg.sv
rtl/isaPkg.sv
rtl/phaseSequencer.sv
rtl/programCounter.sv
rtl/instructionRegister.sv
rtl/busController.sv
rtl/fetchUnit.sv
verif/fetchUnitTb.sv

//--- rtl/busController.sv
`timescale 1ns/1ps

module busController
	import busPkg::*;
	import isaPkg::*;
(
	input  logic                 CLK,
	input  logic                 arstN,
	input  phaseT                phase,
	input  opcodeT               opcode,
	input  logic                 byteOp,
	input  addrSelT              addrSel,
	input  dataSelT              dataSel,
	input  logic [addrWidth-1:0] pc,
	input  logic [dataWidth-1:0] aluResult,
	input  logic [dataWidth-1:0] aluBData,
	input  logic [dataWidth-1:0] regAData,
	input  logic [dataWidth-1:0] din,
	output logic [addrWidth-1:0] addr,
	output logic [dataWidth-1:0] dataOut,
	output logic                 highByte,
	output logic                 rdN,
	output logic                 wrN0,
	output logic                 wrN1,
	output logic [dataWidth-1:0] loadData,
	output logic                 loadValid,
	output logic                 jumpTaken
);

	logic [addrWidth-1:0] selAddr;
	logic [dataWidth-1:0] selData;
	logic [dataWidth-1:0] steerData;
	logic [addrWidth-1:0] addrHold;
	logic [dataWidth-1:0] dataHold;
	logic                 isLoad;
	logic                 isStore;
	logic                 oddByte;
	logic                 readNow;

	assign isLoad    = (opcode == opLoad);
	assign isStore   = (opcode == opStore);
	assign jumpTaken = (opcode == opJump);

	always_comb begin
		case (addrSel)
			addrAluResult: selAddr = addrWidth'(aluResult);
			addrAluBData:  selAddr = addrWidth'(aluBData);
			addrRegAData:  selAddr = addrWidth'(regAData);
			default:       selAddr = pc;
		endcase
		case (dataSel)
			dataRegA:      selData = regAData;
			dataAluResult: selData = aluResult;
			dataAluBData:  selData = aluBData;
			default:       selData = dataWidth'(pc);
		endcase
	end

	// Odd byte store moves the low byte to the high lane
	assign steerData = (isStore && byteOp && selAddr[0]) ?
		{selData[byteWidth-1:0], {byteWidth{1'b0}}} : selData;

	// Operand address and write data stay put through commit
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			addrHold <= '0;
			dataHold <= '0;
		end else if (phase == phaseExecute) begin
			addrHold <= selAddr;
			dataHold <= steerData;
		end
	end

	always_comb begin
		case (phase)
			phaseExecute: addr = selAddr;
			phaseCommit:  addr = addrHold;
			default:      addr = pc; // Instruction address
		endcase
	end

	assign dataOut  = (phase == phaseCommit) ? dataHold : steerData;
	assign oddByte  = byteOp && addr[0];
	assign highByte = (isLoad || isStore) && oddByte &&
		(phase == phaseExecute || phase == phaseCommit);

	assign readNow = (phase == phaseFetch) || (phase == phaseExecute && isLoad);
	assign rdN     = readNow ? strobeOn : strobeOff;
	assign wrN0    = (phase == phaseCommit && isStore && !(byteOp && addrHold[0])) ?
		strobeOn : strobeOff; // Low lane
	assign wrN1    = (phase == phaseCommit && isStore && !(byteOp && !addrHold[0])) ?
		strobeOn : strobeOff; // High lane

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			loadData <= '0;
		end else if (phase == phaseExecute && isLoad) begin
			if (!byteOp) begin
				loadData <= din;
			end else if (selAddr[0]) begin
				loadData <= dataWidth'(din[dataWidth-1:byteWidth]);
			end else begin
				loadData <= dataWidth'(din[byteWidth-1:0]);
			end
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			loadValid <= 1'b0;
		end else begin
			loadValid <= (phase == phaseExecute) && isLoad; // High for commit only
		end
	end

endmodule

//--- rtl/busPkg.sv
package busPkg;

	localparam int addrWidth = 16;
	localparam int dataWidth = 16;
	localparam int byteWidth = 8; // One byte lane

	// Byte addressed memory holding word instructions
	localparam logic [addrWidth-1:0] pcStep = addrWidth'(2);

	// Memory strobes are active low
	localparam logic strobeOn  = 1'b0;
	localparam logic strobeOff = 1'b1;

	typedef enum logic [1:0] {
		phaseFetch   = 2'd0,
		phaseDecode  = 2'd1,
		phaseExecute = 2'd2,
		phaseCommit  = 2'd3
	} phaseT;

endpackage

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
	import busPkg::*;
	import isaPkg::*;
(
	input  logic                 CLK,
	input  logic                 arstN,
	input  logic [dataWidth-1:0] din,
	input  logic [dataWidth-1:0] aluResult,
	input  logic [dataWidth-1:0] aluBData,
	input  logic [dataWidth-1:0] regAData,
	output logic [addrWidth-1:0] addr,
	output logic [dataWidth-1:0] dataOut,
	output logic                 highByte,
	output logic                 rdN,
	output logic                 wrN0,
	output logic                 wrN1,
	output logic [dataWidth-1:0] loadData,
	output logic                 loadValid
);

	phaseT                  phase;
	logic [addrWidth-1:0]   pc;
	opcodeT                 opcode;
	logic                   byteOp;
	addrSelT                addrSel;
	dataSelT                dataSel;
	logic [targetWidth-1:0] jumpTarget;
	logic                   jumpTaken;

	phaseSequencer seq0 (
		.CLK   (CLK),
		.arstN (arstN),
		.phase (phase)
	);

	programCounter pc0 (
		.CLK        (CLK),
		.arstN      (arstN),
		.phase      (phase),
		.jumpTaken  (jumpTaken),
		.jumpTarget (jumpTarget),
		.pc         (pc)
	);

	instructionRegister ir0 (
		.CLK        (CLK),
		.arstN      (arstN),
		.phase      (phase),
		.din        (din),
		.opcode     (opcode),
		.byteOp     (byteOp),
		.addrSel    (addrSel),
		.dataSel    (dataSel),
		.jumpTarget (jumpTarget)
	);

	busController bus0 (
		.CLK       (CLK),
		.arstN     (arstN),
		.phase     (phase),
		.opcode    (opcode),
		.byteOp    (byteOp),
		.addrSel   (addrSel),
		.dataSel   (dataSel),
		.pc        (pc),
		.aluResult (aluResult),
		.aluBData  (aluBData),
		.regAData  (regAData),
		.din       (din),
		.addr      (addr),
		.dataOut   (dataOut),
		.highByte  (highByte),
		.rdN       (rdN),
		.wrN0      (wrN0),
		.wrN1      (wrN1),
		.loadData  (loadData),
		.loadValid (loadValid),
		.jumpTaken (jumpTaken)
	);

endmodule

//--- rtl/instructionRegister.sv
`timescale 1ns/1ps

module instructionRegister
	import busPkg::*;
	import isaPkg::*;
(
	input  logic                   CLK,
	input  logic                   arstN,
	input  phaseT                  phase,
	input  logic [dataWidth-1:0]   din,
	output opcodeT                 opcode,
	output logic                   byteOp,
	output addrSelT                addrSel,
	output dataSelT                dataSel,
	output logic [targetWidth-1:0] jumpTarget
);

	instrWordT instrWord;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			instrWord <= '0; // Decodes as a no-op
		end else if (phase == phaseFetch) begin
			instrWord <= instrWordT'(din);
		end
	end

	always_comb begin
		case (instrWord.mem.opcode)
			opLoad, opStore, opJump: opcode = opcodeT'(instrWord.mem.opcode);
			default:                 opcode = opNop; // Unknown opcodes do nothing
		endcase
	end

	assign byteOp     = instrWord.mem.byteOp;
	assign addrSel    = instrWord.mem.addrSel;
	assign dataSel    = instrWord.mem.dataSel;
	assign jumpTarget = instrWord.jump.target;

endmodule

//--- rtl/isaPkg.sv
package isaPkg;

	localparam int opcodeWidth   = 4;
	localparam int targetWidth   = 12;
	localparam int reservedWidth = 7;

	typedef enum logic [opcodeWidth-1:0] {
		opNop   = 4'd0,
		opLoad  = 4'd1,
		opStore = 4'd2,
		opJump  = 4'd3
	} opcodeT;

	typedef enum logic [1:0] {
		addrAluResult = 2'd0,
		addrAluBData  = 2'd1,
		addrRegAData  = 2'd2,
		addrPc        = 2'd3
	} addrSelT;

	typedef enum logic [1:0] {
		dataRegA      = 2'd0,
		dataAluResult = 2'd1,
		dataAluBData  = 2'd2,
		dataPc        = 2'd3
	} dataSelT;

	// Load and store view
	typedef struct packed {
		logic [opcodeWidth-1:0]   opcode; // Raw, may be unknown
		logic                     byteOp;
		addrSelT                  addrSel;
		dataSelT                  dataSel;
		logic [reservedWidth-1:0] reserved;
	} memOpT;

	// Jump view, opcode in the same bits
	typedef struct packed {
		logic [opcodeWidth-1:0] opcode;
		logic [targetWidth-1:0] target; // Word address of destination
	} jumpOpT;

	typedef union packed {
		memOpT  mem;
		jumpOpT jump;
	} instrWordT;

endpackage

//--- rtl/phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer
	import busPkg::*;
(
	input  logic  CLK,
	input  logic  arstN,
	output phaseT phase
);

	phaseT nextPhase;

	always_comb begin
		case (phase)
			phaseFetch:   nextPhase = phaseDecode;
			phaseDecode:  nextPhase = phaseExecute;
			phaseExecute: nextPhase = phaseCommit;
			default:      nextPhase = phaseFetch; // Commit wraps around
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			phase <= phaseFetch;
		end else begin
			phase <= nextPhase; // One phase per clock
		end
	end

endmodule

//--- rtl/programCounter.sv
`timescale 1ns/1ps

module programCounter
	import busPkg::*;
	import isaPkg::*;
(
	input  logic                   CLK,
	input  logic                   arstN,
	input  phaseT                  phase,
	input  logic                   jumpTaken,
	input  logic [targetWidth-1:0] jumpTarget,
	output logic [addrWidth-1:0]   pc
);

	logic [addrWidth-1:0] jumpDest;

	// Word target to byte address, upper bits zero
	assign jumpDest = addrWidth'({jumpTarget, 1'b0});

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (phase == phaseCommit) begin
			if (jumpTaken) begin
				pc <= jumpDest;
			end else begin
				pc <= pc + pcStep; // Next word
			end
		end
	end

endmodule

//--- verif/fetchUnitTb.sv
`timescale 1ns/1ps

module fetchUnitTb
	import busPkg::*;
	import isaPkg::*;
;

	typedef struct packed {
		logic [15:0] addr, data, loadVal, nextPc, memWord;
		logic        rd, wr0, wr1, high, isLoad;
	} expT;

	logic        CLK;
	logic        arstN;
	logic [15:0] din, aluResult, aluBData, regAData;
	logic [15:0] addr, dataOut, loadData;
	logic        highByte, rdN, wrN0, wrN1, loadValid;

	logic [15:0] mem [0:255]; // Word memory, index is addr[8:1]
	logic [31:0] lfsr;
	logic [15:0] progA[$], progB[$];
	logic        oddQ[$]; // Byte parity per executed instruction
	expT         expCur;
	string       testName;
	logic        checkOn;

	fetchUnit dut0 (.CLK(CLK), .arstN(arstN), .din(din), .aluResult(aluResult),
		.aluBData(aluBData), .regAData(regAData), .addr(addr), .dataOut(dataOut),
		.highByte(highByte), .rdN(rdN), .wrN0(wrN0), .wrN1(wrN1),
		.loadData(loadData), .loadValid(loadValid));

	always #5 CLK = ~CLK; // 10 ns period

	assign din = rdN ? 16'h0000 : mem[addr[8:1]]; // Answers within the cycle

	always @(posedge CLK) begin
		if (!wrN0) mem[addr[8:1]][7:0] <= dataOut[7:0]; // Low lane
		if (!wrN1) mem[addr[8:1]][15:8] <= dataOut[15:8]; // High lane
	end

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] memInstr(input logic [3:0] op, input logic b,
		input logic [1:0] aSel, input logic [1:0] dSel);
		return {op, b, aSel, dSel, 7'h00};
	endfunction

	// Expected bus behavior of one instruction
	function automatic expT refModel(input logic [15:0] instr, input logic [15:0] pcV,
		input logic [15:0] aluR, input logic [15:0] aluB, input logic [15:0] regA,
		input logic [15:0] oldWord);
		logic [3:0]  op;
		logic        b, store, odd;
		logic [15:0] a, d;
		expT         e;
		op = instr[15:12];
		b  = instr[11];
		case (instr[10:9])
			2'd0: a = aluR;
			2'd1: a = aluB;
			2'd2: a = regA;
			default: a = pcV;
		endcase
		case (instr[8:7])
			2'd0: d = regA;
			2'd1: d = aluR;
			2'd2: d = aluB;
			default: d = pcV;
		endcase
		e = '0;
		e.isLoad = (op == 4'd1);
		store = (op == 4'd2);
		odd = b && a[0];
		e.addr = a;
		e.data = (store && odd) ? {d[7:0], 8'h00} : d;
		e.high = (e.isLoad || store) && odd;
		e.rd = !e.isLoad;
		e.wr0 = !(store && !odd);
		e.wr1 = !(store && !(b && !a[0]));
		e.loadVal = !b ? oldWord : (a[0] ? {8'h00, oldWord[15:8]} : {8'h00, oldWord[7:0]});
		if (!store) e.memWord = oldWord;
		else if (!b) e.memWord = d;
		else e.memWord = a[0] ? {d[7:0], oldWord[7:0]} : {oldWord[15:8], d[7:0]};
		e.nextPc = (op == 4'd3) ? {3'b000, instr[11:0], 1'b0} : pcV + 16'd2;
		return e;
	endfunction

	task automatic waitFetch(output int cycles);
		cycles = 0;
		while (dut0.phase != phaseFetch) begin
			if (cycles == 8) begin
				$display("Timeout: the fetch phase did not come back");
				$display("Errors found");
				$fatal(1);
			end
			@(negedge CLK);
			cycles++;
		end
	endtask

	// Compares bus outputs in execute and commit
	always @(negedge CLK) begin
		if (checkOn && dut0.phase == phaseExecute) begin
			checkValue({testName, " exec addr"}, expCur.addr, addr);
			checkValue({testName, " exec dataOut"}, expCur.data, dataOut);
			checkValue({testName, " exec highByte"}, expCur.high, highByte);
			checkValue({testName, " exec rdN"}, expCur.rd, rdN);
			checkValue({testName, " exec wrN"}, 2'b11, {wrN1, wrN0});
			checkValue({testName, " exec loadValid"}, 1'b0, loadValid);
		end else if (checkOn && dut0.phase == phaseCommit) begin
			checkValue({testName, " commit addr"}, expCur.addr, addr);
			checkValue({testName, " commit dataOut"}, expCur.data, dataOut);
			checkValue({testName, " commit highByte"}, expCur.high, highByte);
			checkValue({testName, " commit wrN"}, {expCur.wr1, expCur.wr0}, {wrN1, wrN0});
			checkValue({testName, " commit loadValid"}, expCur.isLoad, loadValid);
			if (expCur.isLoad) checkValue({testName, " loadData"}, expCur.loadVal, loadData);
		end
	end

	initial begin
		logic [15:0] instr, expPc, forced, opAddr, rnd;
		logic [7:0]  lastIdx;
		int          total;
		int          gap;
		CLK = 0;
		arstN = 0;
		aluResult = '0;
		aluBData = '0;
		regAData = '0;
		checkOn = 0;
		testName = "reset";
		lfsr = 32'h9742;
		for (int i = 0; i < 256; i++) mem[i] = {i[7:0], ~i[7:0]} ^ 16'h3C00;
		for (int s = 0; s < 4; s++) begin // Word loads, every addrSel
			progA.push_back(memInstr(4'd1, 1'b0, s[1:0], 2'd0));
			oddQ.push_back(1'b0);
		end
		for (int k = 0; k < 6; k++) begin // Byte loads, both parities
			progA.push_back(memInstr(4'd1, 1'b1, 2'(k % 3), 2'd0));
			oddQ.push_back(k >= 3);
		end
		for (int s = 0; s < 4; s++) begin // Word stores, every dataSel
			progA.push_back(memInstr(4'd2, 1'b0, 2'(s % 3), s[1:0]));
			oddQ.push_back(1'b0);
		end
		for (int k = 0; k < 8; k++) begin // Byte stores
			progA.push_back(memInstr(4'd2, 1'b1, 2'(k % 3), 2'(k % 4)));
			oddQ.push_back(k >= 4);
		end
		progA.push_back(memInstr(4'hA, 1'b1, 2'd1, 2'd2)); // Unknown opcodes
		progA.push_back(memInstr(4'hF, 1'b0, 2'd2, 2'd1));
		progA.push_back({4'd3, 12'd40}); // Jump to word 40
		repeat (3) oddQ.push_back(1'b0);
		progB = '{memInstr(4'd0, 1'b0, 2'd0, 2'd0), memInstr(4'd1, 1'b1, 2'd3, 2'd0),
			memInstr(4'hC, 1'b1, 2'd1, 2'd1)};
		repeat (3) oddQ.push_back(1'b0);
		foreach (progA[i]) mem[i] = progA[i]; // Program loader
		foreach (progB[i]) mem[40 + i] = progB[i];
		total = progA.size() + progB.size();
		repeat (5) @(posedge CLK);
		checkValue("reset wrN", 2'b11, {wrN1, wrN0});
		checkValue("reset loadValid", 1'b0, loadValid);
		@(negedge CLK);
		arstN = 1;
		expPc = 16'h0000;
		for (int k = 0; k <= total; k++) begin
			waitFetch(gap);
			if (k > 0) begin
				checkValue({testName, " fetch spacing"}, 32'd3, gap); // Four cycles each
				checkValue({testName, " memory"}, expCur.memWord, mem[lastIdx]);
			end
			testName = $sformatf("instr%0d", k);
			checkValue({testName, " fetch addr"}, expPc, addr);
			checkValue({testName, " fetch rdN"}, 1'b0, rdN);
			checkValue({testName, " fetch wrN"}, 2'b11, {wrN1, wrN0});
			checkValue({testName, " fetch loadValid"}, 1'b0, loadValid);
			if (k == total) break;
			instr = mem[expPc[8:1]];
			aluResult = randBits(16);
			aluBData = randBits(16);
			regAData = randBits(16);
			rnd = randBits(7);
			forced = {7'h00, 1'b1, rnd[6:0], oddQ[k]}; // Data region 0x100 to 0x1FF
			case (instr[10:9])
				2'd0: aluResult = forced;
				2'd1: aluBData = forced;
				2'd2: regAData = forced;
				default: forced = expPc;
			endcase
			opAddr = forced;
			lastIdx = opAddr[8:1];
			expCur = refModel(instr, expPc, aluResult, aluBData, regAData, mem[lastIdx]);
			expPc = expCur.nextPc;
			checkOn = 1;
			@(negedge CLK);
		end
		$display("No errors");
		$finish;
	end

endmodule
